// File: instruction_decode.f
+incdir+common
common/mips_isa_pkg.sv
common/decode_ctrl_pkg.sv
source/register_file.sv
control_decoder/control_decoder.sv
source/branch_resolver.sv
source/id_ex_register.sv
source/instruction_decode.sv
test/tb_instruction_decode.sv

// File: Bender.yml
package:
  name: instruction_decode

sources:
  - include_dirs:
      - common
    files:
      - common/mips_isa_pkg.sv
      - common/decode_ctrl_pkg.sv
      - source/register_file.sv
      - control_decoder/control_decoder.sv
      - source/branch_resolver.sv
      - source/id_ex_register.sv
      - source/instruction_decode.sv
      - target: test
        files:
          - test/tb_instruction_decode.sv

// File: test/tb_instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module tb_instruction_decode;
   import mips_isa_pkg::*;
   import decode_ctrl_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;
   localparam int CMP_W          = $bits(id_ex_t);

   // Expected decode of one load, store or immediate opcode
   typedef struct packed {
      ex_ctrl_t  ex;
      mem_ctrl_t mem;
      logic      reg_we;
      logic      from_alu;
   } row_t;

   logic                i_clk;
   logic                i_rst;
   logic [`NB_WORD-1:0] i_instruction;
   logic [`NB_WORD-1:0] i_pc;
   wb_port_t            i_wb;
   id_ex_t              o_id_ex;
   redirect_t           o_redirect;
   logic                o_flush;

   logic [31:0]         rng_state;
   logic [`NB_WORD-1:0] pc_count;
   logic [`NB_WORD-1:0] reg_model [32];
   string               test_name;
   redirect_t           redirect_seen;
   id_ex_t              id_ex_seen;
   logic                flush_seen;

   instruction_decode u_dut (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_instruction (i_instruction),
      .i_pc          (i_pc),
      .i_wb          (i_wb),
      .o_id_ex       (o_id_ex),
      .o_redirect    (o_redirect),
      .o_flush       (o_flush)
   );

   always #20 i_clk = ~i_clk;

   ////////////////////
   // Helpers
   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [31:0] encode_r(input func_e f, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd,
                                            input logic [4:0] sh);
      return {OP_R_INST, rs, rt, rd, sh, f};
   endfunction

   function automatic logic [31:0] encode_i(input opcode_e op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] encode_j(input opcode_e op, input logic [25:0] target);
      return {op, target};
   endfunction

   // Columns: ex {aluop, use_imm, imm_unsigned, use_shamt},
   // mem {read_en, write_en, load_unsigned, dsize}, reg_we, from_alu
   function automatic row_t mem_imm_row(input opcode_e op);
      row_t r;
      r = '0;
      case (op)
         OP_LB:   r = '{'{ALU_ADD, 1'b1, 1'b0, 1'b0}, '{1'b1, 1'b0, 1'b0, 2'd0}, 1'b1, 1'b0};
         OP_LH:   r = '{'{ALU_ADD, 1'b1, 1'b0, 1'b0}, '{1'b1, 1'b0, 1'b0, 2'd1}, 1'b1, 1'b0};
         OP_LW:   r = '{'{ALU_ADD, 1'b1, 1'b0, 1'b0}, '{1'b1, 1'b0, 1'b0, 2'd2}, 1'b1, 1'b0};
         OP_LBU:  r = '{'{ALU_ADD, 1'b1, 1'b0, 1'b0}, '{1'b1, 1'b0, 1'b1, 2'd0}, 1'b1, 1'b0};
         OP_LHU:  r = '{'{ALU_ADD, 1'b1, 1'b0, 1'b0}, '{1'b1, 1'b0, 1'b1, 2'd1}, 1'b1, 1'b0};
         OP_LWU:  r = '{'{ALU_ADD, 1'b1, 1'b0, 1'b0}, '{1'b1, 1'b0, 1'b1, 2'd2}, 1'b1, 1'b0};
         OP_SB:   r = '{'{ALU_ADD, 1'b1, 1'b0, 1'b0}, '{1'b0, 1'b1, 1'b0, 2'd0}, 1'b0, 1'b0};
         OP_SH:   r = '{'{ALU_ADD, 1'b1, 1'b0, 1'b0}, '{1'b0, 1'b1, 1'b0, 2'd1}, 1'b0, 1'b0};
         OP_SW:   r = '{'{ALU_ADD, 1'b1, 1'b0, 1'b0}, '{1'b0, 1'b1, 1'b0, 2'd2}, 1'b0, 1'b0};
         OP_ADDI: r = '{'{ALU_ADD, 1'b1, 1'b0, 1'b0}, '{1'b0, 1'b0, 1'b0, 2'd0}, 1'b1, 1'b1};
         OP_SLTI: r = '{'{ALU_SLT, 1'b1, 1'b0, 1'b0}, '{1'b0, 1'b0, 1'b0, 2'd0}, 1'b1, 1'b1};
         OP_ANDI: r = '{'{ALU_AND, 1'b1, 1'b1, 1'b0}, '{1'b0, 1'b0, 1'b0, 2'd0}, 1'b1, 1'b1};
         OP_ORI:  r = '{'{ALU_OR,  1'b1, 1'b1, 1'b0}, '{1'b0, 1'b0, 1'b0, 2'd0}, 1'b1, 1'b1};
         OP_XORI: r = '{'{ALU_XOR, 1'b1, 1'b1, 1'b0}, '{1'b0, 1'b0, 1'b0, 2'd0}, 1'b1, 1'b1};
         OP_LUI:  r = '{'{ALU_LUI, 1'b1, 1'b1, 1'b0}, '{1'b0, 1'b0, 1'b0, 2'd0}, 1'b1, 1'b1};
         default: r = '0;
      endcase
      return r;
   endfunction

   // Function table as {aluop, use_shamt}
   function automatic logic [4:0] func_row(input func_e f);
      case (f)
         FUNC_SLL:  return {ALU_SLL, 1'b1};
         FUNC_SRL:  return {ALU_SRL, 1'b1};
         FUNC_SRA:  return {ALU_SRA, 1'b1};
         FUNC_SLLV: return {ALU_SLL, 1'b0};
         FUNC_SRLV: return {ALU_SRL, 1'b0};
         FUNC_SRAV: return {ALU_SRA, 1'b0};
         FUNC_SUBU: return {ALU_SUB, 1'b0};
         FUNC_AND:  return {ALU_AND, 1'b0};
         FUNC_OR:   return {ALU_OR, 1'b0};
         FUNC_XOR:  return {ALU_XOR, 1'b0};
         FUNC_NOR:  return {ALU_NOR, 1'b0};
         FUNC_SLT:  return {ALU_SLT, 1'b0};
         default:   return {ALU_ADD, 1'b0};
      endcase
   endfunction

   task automatic compare(input string field, input logic [CMP_W-1:0] expected,
                          input logic [CMP_W-1:0] actual);
      if (expected !== actual) begin
         $display("ERR %s %s expected %0h actual %0h", test_name, field, expected, actual);
         $display("Done: errors found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
      @(posedge i_clk);
      i_wb <= '{we: 1'b1, addr: addr, data: data};
      reg_model[addr] = data;
   endtask

   // Redirect sampled mid-cycle, stage register one edge later
   task automatic run_instr(input logic [`NB_WORD-1:0] instr, input wb_port_t wb);
      logic [`NB_WORD-1:0] pc;
      pc = pc_count;
      pc_count = pc_count + 32'd4;
      @(posedge i_clk);
      i_instruction <= instr;
      i_pc          <= pc;
      i_wb          <= wb;
      @(negedge i_clk);
      redirect_seen = o_redirect;
      @(posedge i_clk);
      i_wb <= '0;
      @(negedge i_clk);
      id_ex_seen = o_id_ex;
      flush_seen = o_flush;
      compare("pc", pc, id_ex_seen.pc);
   endtask

   ////////////////////
   // Tests
   task automatic verify_reset();
      test_name = "reset";
      compare("id_ex", '0, o_id_ex);
      compare("flush", 1'b0, o_flush);
      for (int r = 0; r < 32; r++) begin
         run_instr(encode_r(FUNC_ADDU, 5'(r), 5'(31 - r), 5'd1, 5'd0), '0);
         compare("a", '0, id_ex_seen.a);
         compare("b", '0, id_ex_seen.b);
         compare("flush", 1'b0, flush_seen);
      end
   endtask

   task automatic register_read_write();
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [31:0] fresh;
      test_name = "reg_rw";
      for (int r = 1; r < 32; r++) begin
         write_reg(5'(r), next_random());
      end
      for (int k = 0; k < 8; k++) begin
         rs = 5'(next_random());
         rt = 5'(next_random());
         rd = 5'(next_random());
         run_instr(encode_r(FUNC_ADDU, rs, rt, rd, 5'd0), '0);
         compare("a", reg_model[rs], id_ex_seen.a);
         compare("b", reg_model[rt], id_ex_seen.b);
         compare("aluop", ALU_ADD, id_ex_seen.ex.aluop);
         compare("dest", rd, id_ex_seen.wb.dest);
         compare("reg_we", rd != 5'd0, id_ex_seen.wb.reg_we);
      end
      // Write and read of the same register in one cycle
      test_name = "reg_bypass";
      for (int k = 0; k < 4; k++) begin
         rs = 5'(next_random() % 31 + 1);
         fresh = next_random();
         reg_model[rs] = fresh;
         run_instr(encode_r(FUNC_ADDU, rs, rs, 5'd2, 5'd0),
                   '{we: 1'b1, addr: rs, data: fresh});
         compare("a", fresh, id_ex_seen.a);
         compare("b", fresh, id_ex_seen.b);
      end
   endtask

   task automatic load_store_imm_decode();
      opcode_e     ops [15] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_SB, OP_SH,
                                OP_SW, OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
      row_t        row;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
      test_name = "mem_imm";
      foreach (ops[i]) begin
         for (int k = 0; k < 2; k++) begin
            row = mem_imm_row(ops[i]);
            rs = 5'(next_random());
            rt = (k == 0) ? 5'd0 : 5'(next_random() % 31 + 1);
            imm = 16'(next_random());
            run_instr(encode_i(ops[i], rs, rt, imm), '0);
            compare("ex", row.ex, id_ex_seen.ex);
            compare("mem", row.mem, id_ex_seen.mem);
            compare("dest", rt, id_ex_seen.wb.dest);
            compare("reg_we", row.reg_we && (rt != 5'd0), id_ex_seen.wb.reg_we);
            compare("from_alu", row.from_alu, id_ex_seen.wb.from_alu);
            compare("inm", imm, id_ex_seen.inm);
         end
      end
   endtask

   task automatic function_decode();
      func_e       funcs [15] = '{FUNC_SLL, FUNC_SRL, FUNC_SRA, FUNC_SLLV, FUNC_SRLV,
                                  FUNC_SRAV, FUNC_ADDU, FUNC_SUBU, FUNC_AND, FUNC_OR,
                                  FUNC_XOR, FUNC_NOR, FUNC_SLT, FUNC_JR, FUNC_JALR};
      logic [4:0]  row;
      logic [4:0]  rd;
      logic [4:0]  sh;
      logic [31:0] instr;
      test_name = "func";
      foreach (funcs[i]) begin
         rd = 5'(next_random() % 31 + 1);
         sh = 5'(next_random());
         instr = encode_r(funcs[i], 5'(next_random()), 5'(next_random()), rd, sh);
         row = func_row(funcs[i]);
         run_instr(instr, '0);
         compare("aluop", row[4:1], id_ex_seen.ex.aluop);
         compare("use_shamt", row[0], id_ex_seen.ex.use_shamt);
         compare("use_imm", 1'b0, id_ex_seen.ex.use_imm);
         compare("shamt", sh, id_ex_seen.shamt);
         compare("inm", instr[15:0], id_ex_seen.inm);
         compare("dest", rd, id_ex_seen.wb.dest);
         compare("link_pc", funcs[i] == FUNC_JALR, id_ex_seen.wb.link_pc);
      end
   endtask

   task automatic branch_compare();
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [31:0] va;
      logic [31:0] vb;
      logic        taken;
      test_name = "branch";
      for (int k = 0; k < 8; k++) begin
         rs = 5'(next_random() % 15 + 1);
         rt = 5'(next_random() % 15 + 16);
         va = next_random();
         vb = (k % 2 == 0) ? va : next_random();
         write_reg(rs, va);
         write_reg(rt, vb);
         for (int b = 0; b < 2; b++) begin
            // BEQ on even b, BNE on odd
            taken = (b == 0) ? (va == vb) : (va != vb);
            run_instr(encode_i((b == 0) ? OP_BEQ : OP_BNE, rs, rt, 16'(next_random())), '0);
            compare("branch", 1'b1, redirect_seen.branch);
            compare("taken", taken, redirect_seen.branch_taken);
            compare("flush", taken, flush_seen);
            compare("reg_we", 1'b0, id_ex_seen.wb.reg_we);
         end
      end
   endtask

   task automatic jump_redirect();
      logic [25:0] target;
      logic [31:0] va;
      test_name = "jump";
      target = 26'(next_random());
      run_instr(encode_j(OP_J, target), '0);
      compare("jump_inm", 1'b1, redirect_seen.jump_inm);
      compare("target", target, redirect_seen.jump_inm_addr);
      compare("flush", 1'b1, flush_seen);
      compare("reg_we", 1'b0, id_ex_seen.wb.reg_we);
      target = 26'(next_random());
      run_instr(encode_j(OP_JAL, target), '0);
      compare("jump_inm", 1'b1, redirect_seen.jump_inm);
      compare("target", target, redirect_seen.jump_inm_addr);
      compare("flush", 1'b1, flush_seen);
      compare("dest", 5'd31, id_ex_seen.wb.dest);
      compare("reg_we", 1'b1, id_ex_seen.wb.reg_we);
      compare("link_pc", 1'b1, id_ex_seen.wb.link_pc);
      va = next_random();
      write_reg(5'd7, va);
      run_instr(encode_r(FUNC_JR, 5'd7, 5'd0, 5'd0, 5'd0), '0);
      compare("jump_rs", 1'b1, redirect_seen.jump_rs);
      compare("rs_addr", va, redirect_seen.jump_rs_addr);
      compare("jump_inm", 1'b0, redirect_seen.jump_inm);
      compare("flush", 1'b1, flush_seen);
      compare("reg_we", 1'b0, id_ex_seen.wb.reg_we);
      run_instr(encode_r(FUNC_JALR, 5'd7, 5'd0, 5'd31, 5'd0), '0);
      compare("jump_rs", 1'b1, redirect_seen.jump_rs);
      compare("rs_addr", va, redirect_seen.jump_rs_addr);
      compare("flush", 1'b1, flush_seen);
      compare("dest", 5'd31, id_ex_seen.wb.dest);
      compare("link_pc", 1'b1, id_ex_seen.wb.link_pc);
   endtask

   ////////////////////
   // Watchdog
   initial begin
      for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
         @(posedge i_clk);
      end
      $display("Timeout: test sequence still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $fatal(1, "timeout");
   end

   initial begin
      i_clk         = 1'b0;
      i_rst         = 1'b1;
      i_instruction = '0;
      i_pc          = '0;
      i_wb          = '0;
      rng_state     = 32'hf629;
      pc_count      = 32'h0000_0400;
      test_name     = "init";
      for (int r = 0; r < 32; r++) begin
         reg_model[r] = '0;
      end
      for (int c = 0; c < 10; c++) begin
         @(posedge i_clk);
      end
      i_rst <= 1'b0;
      @(negedge i_clk);
      verify_reset();
      register_read_write();
      load_store_imm_decode();
      function_decode();
      branch_compare();
      jump_redirect();
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module instruction_decode (
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  logic [`NB_WORD-1:0]        i_instruction,
   input  logic [`NB_WORD-1:0]        i_pc,
   input  decode_ctrl_pkg::wb_port_t  i_wb,
   output decode_ctrl_pkg::id_ex_t    o_id_ex,
   output decode_ctrl_pkg::redirect_t o_redirect,
   output logic                       o_flush
);
   import mips_isa_pkg::*;
   import decode_ctrl_pkg::*;

   instr_fields_t       fields;
   dec_ctrl_t           ctrl;
   logic [`NB_WORD-1:0] rs_data;
   logic [`NB_WORD-1:0] rt_data;
   logic                flush_req;

   assign fields = instr_fields_t'(i_instruction);

   ////////////////////
   // Operand fetch
   register_file u_register_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_wb      (i_wb),
      .i_rs_addr (fields.rs),
      .i_rt_addr (fields.rt),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   control_decoder u_control_decoder (
      .i_opcode (fields.opcode),
      .i_func   (fields.func),
      .o_ctrl   (ctrl)
   );

   branch_resolver u_branch_resolver (
      .i_ctrl      (ctrl),
      .i_rs_data   (rs_data),
      .i_rt_data   (rt_data),
      .i_j_target  (i_instruction[`NB_J_INM-1:0]),
      .o_redirect  (o_redirect),
      .o_flush_req (flush_req)
   );

   ////////////////////
   // Stage register
   id_ex_register u_id_ex_register (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ctrl      (ctrl),
      .i_rs_data   (rs_data),
      .i_rt_data   (rt_data),
      .i_rt        (fields.rt),
      .i_rd        (fields.rd),
      .i_inm       (i_instruction[`NB_INM-1:0]),
      .i_shamt     (fields.shamt),
      .i_pc        (i_pc),
      .i_flush_req (flush_req),
      .o_id_ex     (o_id_ex),
      .o_flush     (o_flush)
   );

endmodule

`default_nettype wire

// File: source/id_ex_register.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module id_ex_register (
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  decode_ctrl_pkg::dec_ctrl_t i_ctrl,
   input  logic [`NB_WORD-1:0]        i_rs_data,
   input  logic [`NB_WORD-1:0]        i_rt_data,
   input  logic [`NB_REG_ADDR-1:0]    i_rt,
   input  logic [`NB_REG_ADDR-1:0]    i_rd,
   input  logic [`NB_INM-1:0]         i_inm,
   input  logic [`NB_SHAMT-1:0]       i_shamt,
   input  logic [`NB_WORD-1:0]        i_pc,
   input  logic                       i_flush_req,
   output decode_ctrl_pkg::id_ex_t    o_id_ex,
   output logic                       o_flush
);
   import decode_ctrl_pkg::*;

   logic [`NB_REG_ADDR-1:0] dest;
   id_ex_t                  id_ex_next;

   // Link register, then rt for I-type, else rd
   assign dest = i_ctrl.to_ra      ? `NB_REG_ADDR'(`RA_REG) :
                 i_ctrl.ex.use_imm ? i_rt : i_rd;

   always_comb begin
      id_ex_next.ex          = i_ctrl.ex;
      id_ex_next.mem         = i_ctrl.mem;
      id_ex_next.wb.dest     = dest;
      // r0 is never written
      id_ex_next.wb.reg_we   = i_ctrl.reg_we && (dest != '0);
      id_ex_next.wb.from_alu = i_ctrl.from_alu;
      id_ex_next.wb.link_pc  = i_ctrl.link_pc;
      id_ex_next.a           = i_rs_data;
      id_ex_next.b           = i_rt_data;
      id_ex_next.inm         = i_inm;
      id_ex_next.shamt       = i_shamt;
      id_ex_next.pc          = i_pc;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_id_ex <= '0;
         o_flush <= 1'b0;
      end else begin
         o_id_ex <= id_ex_next;
         o_flush <= i_flush_req;
      end
   end

   a_no_r0_write: assert property (@(posedge i_clk) disable iff (i_rst)
      o_id_ex.wb.reg_we |-> (o_id_ex.wb.dest != '0));

   a_no_flush_after_rst: assert property (@(posedge i_clk) i_rst |=> !o_flush);

endmodule

`default_nettype wire

// File: source/branch_resolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module branch_resolver (
   input  decode_ctrl_pkg::dec_ctrl_t i_ctrl,
   input  logic [`NB_WORD-1:0]        i_rs_data,
   input  logic [`NB_WORD-1:0]        i_rt_data,
   input  logic [`NB_J_INM-1:0]       i_j_target,
   output decode_ctrl_pkg::redirect_t o_redirect,
   output logic                       o_flush_req
);
   import decode_ctrl_pkg::*;

   logic equal;
   logic taken;

   assign equal = (i_rs_data == i_rt_data);
   // BNE inverts the compare
   assign taken = i_ctrl.is_branch && (i_ctrl.is_bne ? !equal : equal);

   always_comb begin
      o_redirect.branch        = i_ctrl.is_branch;
      o_redirect.branch_taken  = taken;
      o_redirect.jump_rs       = i_ctrl.jump_rs;
      o_redirect.jump_rs_addr  = i_rs_data;
      o_redirect.jump_inm      = i_ctrl.jump_inm;
      o_redirect.jump_inm_addr = i_j_target;
   end

   // Any change of flow squashes the fetched slot
   assign o_flush_req = taken || i_ctrl.jump_inm || i_ctrl.jump_rs;

endmodule

`default_nettype wire

// File: control_decoder/control_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
   input  mips_isa_pkg::opcode_e      i_opcode,
   input  mips_isa_pkg::func_e        i_func,
   output decode_ctrl_pkg::dec_ctrl_t o_ctrl
);
   import mips_isa_pkg::*;
   import decode_ctrl_pkg::*;

   aluop_e     r_aluop;
   aluop_e     imm_aluop;
   logic       r_shamt;
   logic       r_jump;
   logic       r_link;
   logic [1:0] dsize;

   ////////////////////
   // Function table
   always_comb begin
      case (i_func)
         FUNC_SLL, FUNC_SLLV: r_aluop = ALU_SLL;
         FUNC_SRL, FUNC_SRLV: r_aluop = ALU_SRL;
         FUNC_SRA, FUNC_SRAV: r_aluop = ALU_SRA;
         FUNC_SUBU:           r_aluop = ALU_SUB;
         FUNC_AND:            r_aluop = ALU_AND;
         FUNC_OR:             r_aluop = ALU_OR;
         FUNC_XOR:            r_aluop = ALU_XOR;
         FUNC_NOR:            r_aluop = ALU_NOR;
         FUNC_SLT:            r_aluop = ALU_SLT;
         // ADDU, the register jumps and unknown codes
         default:             r_aluop = ALU_ADD;
      endcase
   end

   // Only the constant shifts take shamt
   assign r_shamt = i_func inside {FUNC_SLL, FUNC_SRL, FUNC_SRA};
   assign r_jump  = i_func inside {FUNC_JR, FUNC_JALR};
   assign r_link  = (i_func == FUNC_JALR);

   // Immediate ALU ops
   always_comb begin
      case (i_opcode)
         OP_ANDI: imm_aluop = ALU_AND;
         OP_ORI:  imm_aluop = ALU_OR;
         OP_XORI: imm_aluop = ALU_XOR;
         OP_LUI:  imm_aluop = ALU_LUI;
         OP_SLTI: imm_aluop = ALU_SLT;
         default: imm_aluop = ALU_ADD;
      endcase
   end

   // Low opcode bits 00 byte, 01 half, 11 word
   assign dsize = (i_opcode[1:0] == 2'b11) ? 2'd2 : i_opcode[1:0];

   ////////////////////
   // Opcode table
   always_comb begin
      o_ctrl = '0;
      case (i_opcode)
         OP_R_INST: begin
            o_ctrl.ex.aluop     = r_aluop;
            o_ctrl.ex.use_shamt = r_shamt;
            o_ctrl.reg_we       = 1'b1;
            o_ctrl.from_alu     = 1'b1;
            o_ctrl.link_pc      = r_link;
            o_ctrl.jump_rs      = r_jump;
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
            o_ctrl.ex.use_imm        = 1'b1;
            o_ctrl.mem.read_en       = 1'b1;
            // Bit 2 marks the unsigned loads
            o_ctrl.mem.load_unsigned = i_opcode[2];
            o_ctrl.mem.dsize         = dsize;
            o_ctrl.reg_we            = 1'b1;
         end
         OP_SB, OP_SH, OP_SW: begin
            o_ctrl.ex.use_imm   = 1'b1;
            o_ctrl.mem.write_en = 1'b1;
            o_ctrl.mem.dsize    = dsize;
         end
         OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            o_ctrl.ex.aluop        = imm_aluop;
            o_ctrl.ex.use_imm      = 1'b1;
            o_ctrl.ex.imm_unsigned = i_opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
            o_ctrl.reg_we          = 1'b1;
            o_ctrl.from_alu        = 1'b1;
         end
         OP_BEQ, OP_BNE: begin
            o_ctrl.ex.use_imm = 1'b1;
            o_ctrl.is_branch  = 1'b1;
            o_ctrl.is_bne     = (i_opcode == OP_BNE);
         end
         OP_J: begin
            o_ctrl.jump_inm = 1'b1;
         end
         OP_JAL: begin
            o_ctrl.jump_inm = 1'b1;
            o_ctrl.to_ra    = 1'b1;
            o_ctrl.reg_we   = 1'b1;
            o_ctrl.link_pc  = 1'b1;
         end
         default: begin
            o_ctrl = '0;
         end
      endcase
   end

   // No opcode both loads and stores
   always_comb begin
      assert #0 (!(o_ctrl.mem.read_en && o_ctrl.mem.write_en))
         else $error("read_en and write_en both set for opcode %0h", i_opcode);
   end

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module register_file (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  decode_ctrl_pkg::wb_port_t i_wb,
   input  logic [`NB_REG_ADDR-1:0]   i_rs_addr,
   input  logic [`NB_REG_ADDR-1:0]   i_rt_addr,
   output logic [`NB_WORD-1:0]       o_rs_data,
   output logic [`NB_WORD-1:0]       o_rt_data
);
   import decode_ctrl_pkg::*;

   localparam int DEPTH = 1 << `NB_REG_ADDR;

   logic [`NB_WORD-1:0] regs [DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb.we) begin
         regs[i_wb.addr] <= i_wb.data;
      end
   end

   // Same-cycle write wins over the stored word
   assign o_rs_data = (i_wb.we && (i_wb.addr == i_rs_addr)) ? i_wb.data : regs[i_rs_addr];
   assign o_rt_data = (i_wb.we && (i_wb.addr == i_rt_addr)) ? i_wb.data : regs[i_rt_addr];

endmodule

`default_nettype wire

// File: common/decode_ctrl_pkg.sv
`default_nettype none

`include "decode_params.svh"

package decode_ctrl_pkg;

   import mips_isa_pkg::*;

   typedef struct packed {
      aluop_e aluop;
      logic   use_imm;
      logic   imm_unsigned;
      logic   use_shamt;
   } ex_ctrl_t;

   // dsize: byte 0, half 1, word 2
   typedef struct packed {
      logic       read_en;
      logic       write_en;
      logic       load_unsigned;
      logic [1:0] dsize;
   } mem_ctrl_t;

   typedef struct packed {
      logic [`NB_REG_ADDR-1:0] dest;
      logic                    reg_we;
      logic                    from_alu;
      logic                    link_pc;
   } wb_ctrl_t;

   // Decoder output, dest is picked later
   typedef struct packed {
      ex_ctrl_t  ex;
      mem_ctrl_t mem;
      logic      reg_we;
      logic      from_alu;
      logic      link_pc;
      logic      to_ra;
      logic      is_branch;
      logic      is_bne;
      logic      jump_inm;
      logic      jump_rs;
   } dec_ctrl_t;

   typedef struct packed {
      logic                    we;
      logic [`NB_REG_ADDR-1:0] addr;
      logic [`NB_WORD-1:0]     data;
   } wb_port_t;

   typedef struct packed {
      ex_ctrl_t             ex;
      mem_ctrl_t            mem;
      wb_ctrl_t             wb;
      logic [`NB_WORD-1:0]  a;
      logic [`NB_WORD-1:0]  b;
      logic [`NB_INM-1:0]   inm;
      logic [`NB_SHAMT-1:0] shamt;
      logic [`NB_WORD-1:0]  pc;
   } id_ex_t;

   typedef struct packed {
      logic                 branch;
      logic                 branch_taken;
      logic                 jump_rs;
      logic [`NB_WORD-1:0]  jump_rs_addr;
      logic                 jump_inm;
      logic [`NB_J_INM-1:0] jump_inm_addr;
   } redirect_t;

endpackage

`default_nettype wire

// File: common/mips_isa_pkg.sv
`default_nettype none

`include "decode_params.svh"

package mips_isa_pkg;

   ////////////////////
   // Primary opcodes
   typedef enum logic [`NB_OPCODE-1:0] {
      OP_R_INST = 6'b000000,
      OP_LB     = 6'b100000,
      OP_LH     = 6'b100001,
      OP_LW     = 6'b100011,
      OP_LBU    = 6'b100100,
      OP_LHU    = 6'b100101,
      OP_LWU    = 6'b100111,
      OP_SB     = 6'b101000,
      OP_SH     = 6'b101001,
      OP_SW     = 6'b101011,
      OP_ADDI   = 6'b001001,
      OP_ANDI   = 6'b001100,
      OP_ORI    = 6'b001101,
      OP_XORI   = 6'b001110,
      OP_LUI    = 6'b001111,
      OP_SLTI   = 6'b001010,
      OP_BEQ    = 6'b000100,
      OP_BNE    = 6'b000101,
      OP_J      = 6'b000010,
      OP_JAL    = 6'b000011
   } opcode_e;

   // R-type function codes
   typedef enum logic [`NB_OPCODE-1:0] {
      FUNC_SLL  = 6'b000000,
      FUNC_SRL  = 6'b000010,
      FUNC_SRA  = 6'b000011,
      FUNC_SLLV = 6'b000100,
      FUNC_SRLV = 6'b000110,
      FUNC_SRAV = 6'b000111,
      FUNC_JR   = 6'b001000,
      FUNC_JALR = 6'b001001,
      FUNC_ADDU = 6'b100001,
      FUNC_SUBU = 6'b100011,
      FUNC_AND  = 6'b100100,
      FUNC_OR   = 6'b100101,
      FUNC_XOR  = 6'b100110,
      FUNC_NOR  = 6'b100111,
      FUNC_SLT  = 6'b101010
   } func_e;

   ////////////////////
   // ALU operations, 4'b1001 left free
   typedef enum logic [`NB_ALUOP-1:0] {
      ALU_ADD = 4'b0000,
      ALU_SUB = 4'b0001,
      ALU_AND = 4'b0010,
      ALU_OR  = 4'b0011,
      ALU_XOR = 4'b0100,
      ALU_NOR = 4'b0101,
      ALU_SRL = 4'b0110,
      ALU_SLL = 4'b0111,
      ALU_SRA = 4'b1000,
      ALU_SLT = 4'b1010,
      ALU_LUI = 4'b1011
   } aluop_e;

   // R-type view, immediate and jump target overlap the low bits
   typedef struct packed {
      opcode_e                 opcode;
      logic [`NB_REG_ADDR-1:0] rs;
      logic [`NB_REG_ADDR-1:0] rt;
      logic [`NB_REG_ADDR-1:0] rd;
      logic [`NB_SHAMT-1:0]    shamt;
      func_e                   func;
   } instr_fields_t;

endpackage

`default_nettype wire

// File: common/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Data path and instruction word
`define NB_WORD     32
`define NB_REG_ADDR 5

// Instruction fields
`define NB_OPCODE   6
`define NB_INM      16
`define NB_SHAMT    5
`define NB_J_INM    26

`define NB_ALUOP    4

// Link register written by JAL
`define RA_REG      31

`endif
